// ==== design/hazard_unit.sv ====
// data hazard detection for the decode stage
// compares rs1/rs2 against the ex and mem destinations, gives
// the forwarding code and the load-use stall
module hazard_unit (
	input  rv32_pkg::rv32_inst_t           cur_inst,
	input  rv32_pkg::rv32_inst_t           cur_ex_inst,
	input  rv32_pkg::rv32_inst_t           cur_mem_inst,
	input  logic [rv32_pkg::REG_IDX_W-1:0] cur_ex_dest,
	input  logic [rv32_pkg::REG_IDX_W-1:0] cur_mem_dest,
	output rv32_pkg::forward_t             forward,
	output logic                           stall
);

	// branches, jumps and stores never count as producers
	function automatic logic is_read_only(input logic [6:0] opcode);
		return (opcode == rv32_pkg::OPC_BRANCH) || (opcode == rv32_pkg::OPC_JAL) ||
			(opcode == rv32_pkg::OPC_JALR) || (opcode == rv32_pkg::OPC_STORE);
	endfunction

	logic ex_live, mem_live;  // stage may produce a value
	logic ex_load;
	logic ex_rs1, ex_rs2;     // ex dest hits a source
	logic mem_rs1, mem_rs2;   // mem dest hits a source

	assign ex_live  = !is_read_only(cur_ex_inst.r.opcode) && (cur_ex_dest != rv32_pkg::ZERO_REG);
	assign mem_live = !is_read_only(cur_mem_inst.r.opcode) &&
		(cur_mem_dest != rv32_pkg::ZERO_REG);
	assign ex_load  = (cur_ex_inst.r.opcode == rv32_pkg::OPC_LOAD);

	assign ex_rs1  = ex_live && (cur_ex_dest == cur_inst.r.rs1);
	assign ex_rs2  = ex_live && (cur_ex_dest == cur_inst.r.rs2);
	assign mem_rs1 = mem_live && (cur_mem_dest == cur_inst.r.rs1);
	assign mem_rs2 = mem_live && (cur_mem_dest == cur_inst.r.rs2);

	//////////////////////////////
	// priority select
	//////////////////////////////
	always_comb begin
		stall = 1'b0;
		if (ex_load) begin
			// load data not ready until after mem
			if (ex_rs1) begin
				stall   = 1'b1;
				forward = rv32_pkg::WB_EX_A_HALT;
			end else if (ex_rs2) begin
				stall   = 1'b1;
				forward = rv32_pkg::WB_EX_B_HALT;
			end else if (mem_rs1 && mem_rs2) forward = rv32_pkg::WB_A_WB_B;
			else if (mem_rs1)                forward = rv32_pkg::WB_EX_A;
			else if (mem_rs2)                forward = rv32_pkg::WB_EX_B;
			else                             forward = rv32_pkg::N_FORWARD;
		end else begin
			// ex result wins over mem for the same source
			if (ex_rs1 && ex_rs2)        forward = rv32_pkg::MEM_A_MEM_B;
			else if (ex_rs1 && mem_rs2)  forward = rv32_pkg::MEM_A_WB_B;
			else if (ex_rs2 && mem_rs1)  forward = rv32_pkg::MEM_B_WB_A;
			else if (mem_rs1 && mem_rs2) forward = rv32_pkg::WB_A_WB_B;
			else if (ex_rs1)             forward = rv32_pkg::MEM_EX_A;
			else if (ex_rs2)             forward = rv32_pkg::MEM_EX_B;
			else if (mem_rs1)            forward = rv32_pkg::WB_EX_A;
			else if (mem_rs2)            forward = rv32_pkg::WB_EX_B;
			else                         forward = rv32_pkg::N_FORWARD;
		end
	end

endmodule

// ==== design/id_ctrl.sv ====
// decode stage handshake control
// four-phase req/ack that captures the instruction and the ex/mem
// context on the req edge and holds it while ack is high
module id_ctrl (
	input  logic                                clock,
	input  logic                                rst_n,
	input  logic                                req,
	output logic                                ack,
	input  rv32_pkg::rv32_inst_t                inst,
	input  rv32_pkg::rv32_inst_t                ex_inst,
	input  rv32_pkg::rv32_inst_t                mem_inst,
	input  logic [rv32_pkg::REG_IDX_W-1:0]      ex_dest,
	input  logic [rv32_pkg::REG_IDX_W-1:0]      mem_dest,
	output rv32_pkg::rv32_inst_t                cur_inst,
	output rv32_pkg::rv32_inst_t                cur_ex_inst,
	output rv32_pkg::rv32_inst_t                cur_mem_inst,
	output logic [rv32_pkg::REG_IDX_W-1:0]      cur_ex_dest,
	output logic [rv32_pkg::REG_IDX_W-1:0]      cur_mem_dest
);

	localparam logic IDLE  = 1'b0; // waiting for req
	localparam logic ACKED = 1'b1; // outputs valid until req drops

	logic state;

	assign ack = (state == ACKED);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state        <= IDLE;
			cur_inst     <= '0; // noop after reset
			cur_ex_inst  <= '0;
			cur_mem_inst <= '0;
			cur_ex_dest  <= '0;
			cur_mem_dest <= '0;
		end else begin
			case (state)
				IDLE: if (req) begin
					state        <= ACKED; // ack on the capture edge
					cur_inst     <= inst;
					cur_ex_inst  <= ex_inst;
					cur_mem_inst <= mem_inst;
					cur_ex_dest  <= ex_dest;
					cur_mem_dest <= mem_dest;
				end
				ACKED: if (!req) state <= IDLE; // first edge with req low
			endcase
		end
	end

endmodule

// ==== design/id_stage.sv ====
// rv32i instruction decode stage, top level
// handshake control plus decoder, immediate, register file
// and hazard unit, all outputs live while ack is high
module id_stage (
	input  logic                           clock,
	input  logic                           rst_n,
	// request side
	input  logic                           req,
	output logic                           ack,
	input  rv32_pkg::rv32_inst_t           inst,
	input  rv32_pkg::rv32_inst_t           ex_inst,
	input  logic [rv32_pkg::REG_IDX_W-1:0] ex_dest,
	input  rv32_pkg::rv32_inst_t           mem_inst,
	input  logic [rv32_pkg::REG_IDX_W-1:0] mem_dest,
	// writeback port
	input  logic                           wb_en,
	input  logic [rv32_pkg::REG_IDX_W-1:0] wb_idx,
	input  logic [rv32_pkg::XLEN-1:0]      wb_data,
	// decoded controls
	output rv32_pkg::alu_opa_sel_t         opa_sel,
	output rv32_pkg::alu_opb_sel_t         opb_sel,
	output rv32_pkg::alu_func_t            alu_func,
	output logic [rv32_pkg::REG_IDX_W-1:0] dest_idx,
	output logic                           rd_mem,
	output logic                           wr_mem,
	output logic                           cond_branch,
	output logic                           uncond_branch,
	output logic                           halt,
	output logic                           illegal,
	output logic                           valid,
	// operands and hazards
	output logic [rv32_pkg::XLEN-1:0]      rs1_value,
	output logic [rv32_pkg::XLEN-1:0]      rs2_value,
	output logic [rv32_pkg::XLEN-1:0]      imm,
	output rv32_pkg::forward_t             forward,
	output logic                           stall
);

	rv32_pkg::rv32_inst_t           cur_inst;     // captured word
	rv32_pkg::rv32_inst_t           cur_ex_inst;  // captured context
	rv32_pkg::rv32_inst_t           cur_mem_inst;
	logic [rv32_pkg::REG_IDX_W-1:0] cur_ex_dest;
	logic [rv32_pkg::REG_IDX_W-1:0] cur_mem_dest;

	id_ctrl ctrl_0 (
		.clock, .rst_n, .req, .ack,
		.inst, .ex_inst, .mem_inst, .ex_dest, .mem_dest,
		.cur_inst, .cur_ex_inst, .cur_mem_inst, .cur_ex_dest, .cur_mem_dest
	);

	hazard_unit hazard_0 (
		.cur_inst, .cur_ex_inst, .cur_mem_inst, .cur_ex_dest, .cur_mem_dest,
		.forward, .stall
	);

	// bubble when stall is up
	inst_decoder decoder_0 (
		.cur_inst, .stall,
		.opa_sel, .opb_sel, .alu_func, .dest_idx,
		.rd_mem, .wr_mem, .cond_branch, .uncond_branch,
		.halt, .illegal, .valid
	);

	imm_gen imm_0 (.cur_inst, .opb_sel, .imm);

	regfile regf_0 (
		.clock,
		.rs1_idx   (cur_inst.r.rs1),
		.rs2_idx   (cur_inst.r.rs2),
		.rs1_value,
		.rs2_value,
		.wb_en, .wb_idx, .wb_data
	);

endmodule

// ==== design/imm_gen.sv ====
// immediate generator
// picks the format from the operand b select and sign-extends
// bit 31 of the word, zero when operand b is rs2
module imm_gen (
	input  rv32_pkg::rv32_inst_t      cur_inst,
	input  rv32_pkg::alu_opb_sel_t    opb_sel,
	output logic [rv32_pkg::XLEN-1:0] imm
);

	always_comb begin
		case (opb_sel)
			rv32_pkg::OPB_IS_I_IMM: // loads, jalr, op-imm
				imm = {{(rv32_pkg::XLEN-12){cur_inst.i.imm[11]}}, cur_inst.i.imm};
			rv32_pkg::OPB_IS_S_IMM:
				imm = {{(rv32_pkg::XLEN-12){cur_inst.s.imm_hi[6]}},
					cur_inst.s.imm_hi, cur_inst.s.imm_lo};
			rv32_pkg::OPB_IS_B_IMM: // halfword offset, bit 0 forced low
				imm = {{(rv32_pkg::XLEN-12){cur_inst.b.imm12}},
					cur_inst.b.imm11, cur_inst.b.imm10_5, cur_inst.b.imm4_1, 1'b0};
			rv32_pkg::OPB_IS_U_IMM: // upper 20, low 12 zero
				imm = {cur_inst.u.imm, 12'b0};
			rv32_pkg::OPB_IS_J_IMM:
				imm = {{(rv32_pkg::XLEN-20){cur_inst.j.imm20}},
					cur_inst.j.imm19_12, cur_inst.j.imm11, cur_inst.j.imm10_1, 1'b0};
			default:
				imm = '0; // register operand, no immediate
		endcase
	end

endmodule

// ==== design/inst_decoder.sv ====
// rv32i instruction decoder, purely combinational
// maps opcode/funct3/funct7 onto datapath selects and flags,
// forces a bubble while the hazard unit holds a stall
module inst_decoder (
	input  rv32_pkg::rv32_inst_t           cur_inst,
	input  logic                           stall,
	output rv32_pkg::alu_opa_sel_t         opa_sel,
	output rv32_pkg::alu_opb_sel_t         opb_sel,
	output rv32_pkg::alu_func_t            alu_func,
	output logic [rv32_pkg::REG_IDX_W-1:0] dest_idx,
	output logic                           rd_mem,
	output logic                           wr_mem,
	output logic                           cond_branch,
	output logic                           uncond_branch,
	output logic                           halt,
	output logic                           illegal,
	output logic                           valid
);

	logic       wr_rd;  // inst writes rd
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign funct3 = cur_inst.r.funct3;
	assign funct7 = cur_inst.r.funct7;
	assign valid  = !illegal; // bubble and noop stay valid

	always_comb begin
		// noop defaults, also the stall bubble
		opa_sel       = rv32_pkg::OPA_IS_RS1;
		opb_sel       = rv32_pkg::OPB_IS_RS2;
		alu_func      = rv32_pkg::ALU_ADD;
		wr_rd         = 1'b0;
		rd_mem        = 1'b0;
		wr_mem        = 1'b0;
		cond_branch   = 1'b0;
		uncond_branch = 1'b0;
		halt          = 1'b0;
		illegal       = 1'b0;
		if (!stall) begin
			case (cur_inst.r.opcode)
				rv32_pkg::OPC_LUI: begin
					wr_rd   = 1'b1;
					opa_sel = rv32_pkg::OPA_IS_ZERO; // 0 + u_imm
					opb_sel = rv32_pkg::OPB_IS_U_IMM;
				end
				rv32_pkg::OPC_AUIPC: begin
					wr_rd   = 1'b1;
					opa_sel = rv32_pkg::OPA_IS_PC;
					opb_sel = rv32_pkg::OPB_IS_U_IMM;
				end
				rv32_pkg::OPC_JAL: begin
					wr_rd         = 1'b1;
					opa_sel       = rv32_pkg::OPA_IS_PC;
					opb_sel       = rv32_pkg::OPB_IS_J_IMM;
					uncond_branch = 1'b1;
				end
				rv32_pkg::OPC_JALR: begin
					wr_rd         = 1'b1;
					opb_sel       = rv32_pkg::OPB_IS_I_IMM; // rs1 + i_imm
					uncond_branch = 1'b1;
					illegal       = (funct3 != 3'b000);
				end
				rv32_pkg::OPC_BRANCH: begin
					opa_sel     = rv32_pkg::OPA_IS_PC; // target calc
					opb_sel     = rv32_pkg::OPB_IS_B_IMM;
					cond_branch = 1'b1;
					illegal     = (funct3 == 3'b010) || (funct3 == 3'b011);
				end
				rv32_pkg::OPC_LOAD: begin
					wr_rd   = 1'b1;
					opb_sel = rv32_pkg::OPB_IS_I_IMM;
					rd_mem  = 1'b1;
					illegal = (funct3 == 3'b011) || (funct3 > 3'b101); // lb..lhu only
				end
				rv32_pkg::OPC_STORE: begin
					opb_sel = rv32_pkg::OPB_IS_S_IMM;
					wr_mem  = 1'b1;
					illegal = (funct3 > 3'b010); // sb sh sw
				end
				rv32_pkg::OPC_OP_IMM: begin
					wr_rd   = 1'b1;
					opb_sel = rv32_pkg::OPB_IS_I_IMM;
					case (funct3)
						3'b000: alu_func = rv32_pkg::ALU_ADD;
						3'b010: alu_func = rv32_pkg::ALU_SLT;
						3'b011: alu_func = rv32_pkg::ALU_SLTU;
						3'b100: alu_func = rv32_pkg::ALU_XOR;
						3'b110: alu_func = rv32_pkg::ALU_OR;
						3'b111: alu_func = rv32_pkg::ALU_AND;
						3'b001: begin
							alu_func = rv32_pkg::ALU_SLL;
							illegal  = (funct7 != 7'b0000000); // shamt[5] not in rv32
						end
						default: begin // 3'b101, srli or srai
							alu_func = funct7[5] ? rv32_pkg::ALU_SRA : rv32_pkg::ALU_SRL;
							illegal  = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
						end
					endcase
				end
				rv32_pkg::OPC_OP: begin
					wr_rd = 1'b1;
					case ({funct7, funct3})
						10'b0000000_000: alu_func = rv32_pkg::ALU_ADD;
						10'b0100000_000: alu_func = rv32_pkg::ALU_SUB;
						10'b0000000_001: alu_func = rv32_pkg::ALU_SLL;
						10'b0000000_010: alu_func = rv32_pkg::ALU_SLT;
						10'b0000000_011: alu_func = rv32_pkg::ALU_SLTU;
						10'b0000000_100: alu_func = rv32_pkg::ALU_XOR;
						10'b0000000_101: alu_func = rv32_pkg::ALU_SRL;
						10'b0100000_101: alu_func = rv32_pkg::ALU_SRA;
						10'b0000000_110: alu_func = rv32_pkg::ALU_OR;
						10'b0000000_111: alu_func = rv32_pkg::ALU_AND;
						default:         illegal  = 1'b1; // mul/div land here too
					endcase
				end
				rv32_pkg::OPC_SYSTEM: begin
					halt    = (cur_inst == rv32_pkg::WFI_WORD);
					illegal = (cur_inst != rv32_pkg::WFI_WORD); // csr dropped
				end
				7'b0000000: illegal = (cur_inst != '0); // only all-zero is the noop
				default:    illegal = 1'b1;
			endcase
		end
		// illegal words leave the datapath as a noop
		if (illegal) begin
			opa_sel       = rv32_pkg::OPA_IS_RS1;
			opb_sel       = rv32_pkg::OPB_IS_RS2;
			alu_func      = rv32_pkg::ALU_ADD;
			wr_rd         = 1'b0;
			rd_mem        = 1'b0;
			wr_mem        = 1'b0;
			cond_branch   = 1'b0;
			uncond_branch = 1'b0;
		end
		dest_idx = wr_rd ? cur_inst.r.rd : rv32_pkg::ZERO_REG;
	end

endmodule

// ==== design/regfile.sv ====
// integer register file, 32 x xlen
// two combinational read ports, one write port from writeback
// x0 reads zero and ignores writes
module regfile (
	input  logic                           clock,
	input  logic [rv32_pkg::REG_IDX_W-1:0] rs1_idx,
	input  logic [rv32_pkg::REG_IDX_W-1:0] rs2_idx,
	output logic [rv32_pkg::XLEN-1:0]      rs1_value,
	output logic [rv32_pkg::XLEN-1:0]      rs2_value,
	input  logic                           wb_en,
	input  logic [rv32_pkg::REG_IDX_W-1:0] wb_idx,
	input  logic [rv32_pkg::XLEN-1:0]      wb_data
);

	localparam int DEPTH = 2 ** rv32_pkg::REG_IDX_W;

	logic [rv32_pkg::XLEN-1:0] regs [DEPTH]; // entry 0 never written

	// reads, no write bypass
	assign rs1_value = (rs1_idx == rv32_pkg::ZERO_REG) ? '0 : regs[rs1_idx];
	assign rs2_value = (rs2_idx == rv32_pkg::ZERO_REG) ? '0 : regs[rs2_idx];

	// write port
	always_ff @(posedge clock) begin
		if (wb_en && (wb_idx != rv32_pkg::ZERO_REG)) begin
			regs[wb_idx] <= wb_data;
		end
	end

endmodule

// ==== design/rv32_pkg.sv ====
// rv32 shared definitions for the instruction decode stage
// widths, base opcodes, datapath select encodings, forward codes
// and the instruction word with one view per encoding format
package rv32_pkg;

	//////////////////////////////
	// widths and fixed indices
	//////////////////////////////
	localparam int XLEN      = 32;
	localparam int REG_IDX_W = 5;
	localparam logic [REG_IDX_W-1:0] ZERO_REG = '0; // x0, hardwired zero

	//////////////////////////////
	// base opcodes, inst[6:0]
	//////////////////////////////
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011; // wfi and csr live here

	localparam logic [XLEN-1:0] WFI_WORD = 32'h1050_0073;

	// operand a mux
	typedef enum logic [1:0] {
		OPA_IS_RS1  = 2'h0,
		OPA_IS_PC   = 2'h1,
		OPA_IS_ZERO = 2'h2
	} alu_opa_sel_t;

	// operand b mux, also picks the immediate format
	typedef enum logic [2:0] {
		OPB_IS_RS2   = 3'h0,
		OPB_IS_I_IMM = 3'h1,
		OPB_IS_S_IMM = 3'h2,
		OPB_IS_B_IMM = 3'h3,
		OPB_IS_U_IMM = 3'h4,
		OPB_IS_J_IMM = 3'h5
	} alu_opb_sel_t;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'h0,
		ALU_SUB  = 4'h1,
		ALU_SLT  = 4'h2,
		ALU_SLTU = 4'h3,
		ALU_AND  = 4'h4,
		ALU_OR   = 4'h5,
		ALU_XOR  = 4'h6,
		ALU_SLL  = 4'h7,
		ALU_SRL  = 4'h8,
		ALU_SRA  = 4'h9
	} alu_func_t;

	// forwarding code, MEM_* from ex/mem latch, WB_* from mem/wb latch
	// *_HALT marks a load-use stall
	typedef enum logic [3:0] {
		N_FORWARD    = 4'h0,
		MEM_EX_A     = 4'h1,
		MEM_EX_B     = 4'h2,
		WB_EX_A      = 4'h3,
		WB_EX_B      = 4'h4,
		MEM_A_MEM_B  = 4'h5,
		MEM_A_WB_B   = 4'h6,
		MEM_B_WB_A   = 4'h7,
		WB_A_WB_B    = 4'h8,
		WB_EX_A_HALT = 4'h9,
		WB_EX_B_HALT = 4'ha
	} forward_t;

	//////////////////////////////
	// instruction formats
	//////////////////////////////
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi; // imm[11:5]
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo; // imm[4:0]
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm; // imm[31:12]
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r; // field decode and hazard compares
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} rv32_inst_t;

endpackage

// ==== id_stage.f ====
+incdir+testbench
design/rv32_pkg.sv
design/id_ctrl.sv
design/inst_decoder.sv
design/imm_gen.sv
design/regfile.sv
design/hazard_unit.sv
design/id_stage.sv
testbench/tb_id_stage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with verilator
# exit status is nonzero when the testbench stops on an error
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f id_stage.f --top-module tb_id_stage -Mdir obj_dir
./obj_dir/Vtb_id_stage

// ==== testbench/tb_ref.svh ====
// reference model for the decode stage testbench
// expected selects, immediates and forward codes from the rv32i
// encoding rules, plus the register shadow and the lcg
`ifndef TB_REF_SVH
`define TB_REF_SVH

// expected decode, same bit order as the compared output vector
typedef struct packed {
	logic [1:0] opa;
	logic [2:0] opb;
	logic [3:0] func;
	logic [4:0] dest;
	logic       rd_mem;
	logic       wr_mem;
	logic       cond;
	logic       uncond;
	logic       halt;
	logic       illegal;
	logic       valid;
} dec_t;

logic [31:0] shadow [32];          // expected register file
logic [31:0] lcg_state = 32'd4681; // seed

function automatic logic [31:0] next_rand();
	logic [15:0] hi;
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	hi        = lcg_state[31:16]; // low lcg bits repeat too soon
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return {hi, lcg_state[31:16]};
endfunction

// alt picks sub / sra
function automatic logic [3:0] alu_of_f3(input logic [2:0] f3, input logic alt);
	case (f3)
		3'd0:    return alt ? rv32_pkg::ALU_SUB : rv32_pkg::ALU_ADD;
		3'd1:    return rv32_pkg::ALU_SLL;
		3'd2:    return rv32_pkg::ALU_SLT;
		3'd3:    return rv32_pkg::ALU_SLTU;
		3'd4:    return rv32_pkg::ALU_XOR;
		3'd5:    return alt ? rv32_pkg::ALU_SRA : rv32_pkg::ALU_SRL;
		3'd6:    return rv32_pkg::ALU_OR;
		default: return rv32_pkg::ALU_AND;
	endcase
endfunction

function automatic dec_t ref_decode(input logic [31:0] w, input logic stall);
	dec_t       d;
	logic       wr;
	logic       ok;
	logic [2:0] f3;
	logic [6:0] f7;
	d  = '0;
	wr = 1'b0;
	ok = 1'b1;
	f3 = w[14:12];
	f7 = w[31:25];
	case (w[6:0])
		rv32_pkg::OPC_LUI:   {wr, d.opa, d.opb} = {1'b1, rv32_pkg::OPA_IS_ZERO, rv32_pkg::OPB_IS_U_IMM};
		rv32_pkg::OPC_AUIPC: {wr, d.opa, d.opb} = {1'b1, rv32_pkg::OPA_IS_PC, rv32_pkg::OPB_IS_U_IMM};
		rv32_pkg::OPC_JAL:
			{wr, d.opa, d.opb, d.uncond} = {1'b1, rv32_pkg::OPA_IS_PC, rv32_pkg::OPB_IS_J_IMM, 1'b1};
		rv32_pkg::OPC_JALR: begin
			{wr, d.opb, d.uncond} = {1'b1, rv32_pkg::OPB_IS_I_IMM, 1'b1};
			ok = (f3 == 3'd0);
		end
		rv32_pkg::OPC_BRANCH: begin
			{d.opa, d.opb, d.cond} = {rv32_pkg::OPA_IS_PC, rv32_pkg::OPB_IS_B_IMM, 1'b1};
			ok = !(f3 inside {3'd2, 3'd3}); // no branch for 010, 011
		end
		rv32_pkg::OPC_LOAD: begin
			{wr, d.opb, d.rd_mem} = {1'b1, rv32_pkg::OPB_IS_I_IMM, 1'b1};
			ok = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
		end
		rv32_pkg::OPC_STORE: begin
			{d.opb, d.wr_mem} = {rv32_pkg::OPB_IS_S_IMM, 1'b1};
			ok = (f3 <= 3'd2);
		end
		rv32_pkg::OPC_OP_IMM: begin
			{wr, d.opb} = {1'b1, rv32_pkg::OPB_IS_I_IMM};
			d.func = alu_of_f3(f3, (f3 == 3'd5) && f7[5]); // addi has no sub
			if (f3 == 3'd1) ok = (f7 == 7'h00);
			if (f3 == 3'd5) ok = (f7 == 7'h00) || (f7 == 7'h20);
		end
		rv32_pkg::OPC_OP: begin
			wr     = 1'b1;
			d.func = alu_of_f3(f3, f7[5]);
			ok     = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
		end
		rv32_pkg::OPC_SYSTEM: begin
			d.halt = (w == rv32_pkg::WFI_WORD); // csr words illegal
			ok     = d.halt;
		end
		default: ok = (w == 32'h0); // all-zero noop only
	endcase
	if (stall || !ok) begin
		d         = '0; // bubble or illegal, noop selects
		wr        = 1'b0;
		d.illegal = !stall;
	end
	d.dest  = wr ? w[11:7] : rv32_pkg::ZERO_REG;
	d.valid = !d.illegal;
	return d;
endfunction

function automatic logic [31:0] ref_imm(input logic [31:0] w, input logic [2:0] opb);
	case (opb)
		rv32_pkg::OPB_IS_I_IMM: return {{20{w[31]}}, w[31:20]};
		rv32_pkg::OPB_IS_S_IMM: return {{20{w[31]}}, w[31:25], w[11:7]};
		rv32_pkg::OPB_IS_B_IMM: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		rv32_pkg::OPB_IS_U_IMM: return {w[31:12], 12'h000};
		rv32_pkg::OPB_IS_J_IMM: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		default:                return 32'h0;
	endcase
endfunction

function automatic logic is_producer(input logic [6:0] opc);
	return !(opc inside {rv32_pkg::OPC_BRANCH, rv32_pkg::OPC_JAL, rv32_pkg::OPC_JALR,
		rv32_pkg::OPC_STORE});
endfunction

// result is {stall, forward}
function automatic logic [4:0] ref_forward(input logic [31:0] w, input logic [31:0] ex_w,
		input logic [4:0] ex_d, input logic [31:0] mem_w, input logic [4:0] mem_d);
	logic ex_ok;
	logic mem_ok;
	logic e1, e2, m1, m2;
	ex_ok  = is_producer(ex_w[6:0]) && (ex_d != rv32_pkg::ZERO_REG);
	mem_ok = is_producer(mem_w[6:0]) && (mem_d != rv32_pkg::ZERO_REG);
	e1 = ex_ok && (ex_d == w[19:15]);
	e2 = ex_ok && (ex_d == w[24:20]);
	m1 = mem_ok && (mem_d == w[19:15]);
	m2 = mem_ok && (mem_d == w[24:20]);
	if (ex_w[6:0] == rv32_pkg::OPC_LOAD) begin
		if (e1) return {1'b1, rv32_pkg::WB_EX_A_HALT}; // load-use
		if (e2) return {1'b1, rv32_pkg::WB_EX_B_HALT};
	end else begin
		if (e1 && e2) return {1'b0, rv32_pkg::MEM_A_MEM_B};
		if (e1 && m2) return {1'b0, rv32_pkg::MEM_A_WB_B};
		if (e2 && m1) return {1'b0, rv32_pkg::MEM_B_WB_A};
	end
	if (m1 && m2) return {1'b0, rv32_pkg::WB_A_WB_B};
	if (e1)       return {1'b0, rv32_pkg::MEM_EX_A}; // only reached without a load
	if (e2)       return {1'b0, rv32_pkg::MEM_EX_B};
	if (m1)       return {1'b0, rv32_pkg::WB_EX_A};
	if (m2)       return {1'b0, rv32_pkg::WB_EX_B};
	return {1'b0, rv32_pkg::N_FORWARD};
endfunction

`endif

// ==== testbench/tb_id_stage.sv ====
// testbench for the decode stage
// four-phase requests with random instructions and ex/mem context,
// writeback traffic, every output checked while ack is high
module tb_id_stage;

	localparam int N_RAND     = 400;
	localparam int N_TRANS    = N_RAND + 4;      // noop, wfi, csr, mul
	localparam int N_WRITES   = 32 + N_RAND / 4; // fill + one per 4 requests
	localparam int MAX_CYCLES = 16 + 12 * (N_TRANS + N_WRITES) + 100;

	logic                           clock = 1'b0;
	logic                           rst_n, req, ack;
	rv32_pkg::rv32_inst_t           inst, ex_inst, mem_inst;
	logic [rv32_pkg::REG_IDX_W-1:0] ex_dest, mem_dest, wb_idx, dest_idx;
	logic                           wb_en;
	logic [rv32_pkg::XLEN-1:0]      wb_data, rs1_value, rs2_value, imm;
	rv32_pkg::alu_opa_sel_t         opa_sel;
	rv32_pkg::alu_opb_sel_t         opb_sel;
	rv32_pkg::alu_func_t            alu_func;
	rv32_pkg::forward_t             forward;
	logic rd_mem, wr_mem, cond_branch, uncond_branch, halt, illegal, valid, stall;
	int                             cycles = 0;

	`include "tb_ref.svh"

	dec_t       exp_dec;
	logic [4:0] exp_hz; // {stall, forward}

	id_stage dut_i (.*);

	always #10 clock = ~clock;

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	//////////////////////////////
	// checker, mid-cycle
	//////////////////////////////
	always @(negedge clock) begin
		if (rst_n && ack) begin
			exp_hz  = ref_forward(inst, ex_inst, ex_dest, mem_inst, mem_dest);
			exp_dec = ref_decode(inst, exp_hz[4]);
			assert ({stall, forward} == exp_hz) else stop_on_error($sformatf(
				"MISMATCH at %0t: forward of %h got %h exp %h", $time, inst, {stall, forward}, exp_hz));
			assert ({opa_sel, opb_sel, alu_func, dest_idx, rd_mem, wr_mem, cond_branch,
				uncond_branch, halt, illegal, valid} == exp_dec) else stop_on_error($sformatf(
				"MISMATCH at %0t: decode of %h got %h exp %h", $time, inst, {opa_sel, opb_sel,
				alu_func, dest_idx, rd_mem, wr_mem, cond_branch, uncond_branch, halt, illegal,
				valid}, exp_dec));
			assert (imm == ref_imm(inst, exp_dec.opb)) else stop_on_error($sformatf(
				"MISMATCH at %0t: imm of %h got %h", $time, inst, imm));
			assert (rs1_value == shadow[inst.r.rs1] && rs2_value == shadow[inst.r.rs2])
				else stop_on_error($sformatf("MISMATCH at %0t: operands of %h got %h %h",
				$time, inst, rs1_value, rs2_value));
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
			stop_on_error($sformatf("timeout, run not done after %0d cycles", cycles));
	end

	// one four-phase request, req held hold extra cycles
	task automatic run_transaction(input logic [31:0] w, input logic [31:0] ex_w,
			input logic [4:0] ex_d, input logic [31:0] mem_w, input logic [4:0] mem_d,
			input int hold);
		@(posedge clock);
		inst     <= w;
		ex_inst  <= ex_w;
		ex_dest  <= ex_d;
		mem_inst <= mem_w;
		mem_dest <= mem_d;
		req      <= 1'b1;
		@(negedge clock);
		while (!ack) @(negedge clock); // timeout guards this
		repeat (hold) begin
			@(negedge clock);
			assert (ack) else stop_on_error("ack dropped while req was still high");
		end
		@(posedge clock);
		req <= 1'b0;
		@(negedge clock);
		assert (ack) else stop_on_error("ack fell before the DUT could see req low");
		@(negedge clock);
		assert (!ack) else stop_on_error("ack still high one cycle after req fell");
	endtask

	task automatic write_reg(input logic [4:0] idx, input logic [31:0] data);
		@(posedge clock);
		wb_en   <= 1'b1;
		wb_idx  <= idx;
		wb_data <= data;
		@(posedge clock);
		wb_en <= 1'b0;
		if (idx != rv32_pkg::ZERO_REG) shadow[idx] = data; // x0 stays zero
	endtask

	function automatic logic [31:0] random_inst();
		logic [31:0] w;
		w = next_rand(); // fields and immediates random, either sign
		case (next_rand() % 12)
			0:  w[6:0] = rv32_pkg::OPC_LUI;
			1:  w[6:0] = rv32_pkg::OPC_AUIPC;
			2:  w[6:0] = rv32_pkg::OPC_JAL;
			3:  w[14:0] = {3'b000, w[11:7], rv32_pkg::OPC_JALR};
			4:  w[6:0] = rv32_pkg::OPC_BRANCH;
			5:  w[6:0] = rv32_pkg::OPC_LOAD;
			6:  w[6:0] = rv32_pkg::OPC_STORE;
			7:  w[6:0] = rv32_pkg::OPC_OP_IMM;
			8, 9: begin
				w[6:0]   = (next_rand() % 2 == 0) ? rv32_pkg::OPC_OP : rv32_pkg::OPC_OP_IMM;
				w[31]    = 1'b0; // funct7 0 or 0x20
				w[29:25] = 5'b0;
			end
			10:      w[6:0] = rv32_pkg::OPC_OP; // raw funct7, mostly illegal
			default: ;                          // raw word
		endcase
		return w;
	endfunction

	function automatic logic [31:0] context_inst();
		logic [31:0] w;
		w = next_rand();
		case (next_rand() % 8)
			0, 1:    w[6:0] = rv32_pkg::OPC_LOAD; // load-use more often
			2:       w[6:0] = rv32_pkg::OPC_BRANCH;
			3:       w[6:0] = rv32_pkg::OPC_STORE;
			4:       w[6:0] = rv32_pkg::OPC_JAL;
			5:       w[6:0] = rv32_pkg::OPC_JALR;
			6:       w[6:0] = rv32_pkg::OPC_OP_IMM;
			default: w[6:0] = rv32_pkg::OPC_OP;
		endcase
		return w;
	endfunction

	// dest biased toward the sources
	function automatic logic [4:0] pick_dest(input logic [31:0] w);
		case (next_rand() % 4)
			0:       return w[19:15];
			1:       return w[24:20];
			2:       return 5'(next_rand());
			default: return rv32_pkg::ZERO_REG;
		endcase
	endfunction

	initial begin
		logic [31:0] w;
		for (int i = 0; i < 32; i++) shadow[i] = 32'h0;
		rst_n    <= 1'b0;
		req      <= 1'b0;
		inst     <= '0;
		ex_inst  <= '0;
		mem_inst <= '0;
		ex_dest  <= '0;
		mem_dest <= '0;
		wb_en    <= 1'b0;
		wb_idx   <= '0;
		wb_data  <= '0;
		repeat (16) @(posedge clock);
		rst_n <= 1'b1;
		@(negedge clock);
		assert (!ack) else stop_on_error("ack high right after reset");
		run_transaction(32'h0, 32'h0, 5'd0, 32'h0, 5'd0, 0); // noop
		for (int i = 0; i < 32; i++) write_reg(5'(i), next_rand()); // x0 write dropped
		run_transaction(rv32_pkg::WFI_WORD, 32'h0, 5'd0, 32'h0, 5'd0, 1);
		run_transaction(32'h3001_10f3, 32'h0, 5'd0, 32'h0, 5'd0, 1); // csrrw
		run_transaction(32'h0220_80b3, 32'h0, 5'd0, 32'h0, 5'd0, 1); // mul
		for (int n = 0; n < N_RAND; n++) begin
			w = random_inst();
			run_transaction(w, context_inst(), pick_dest(w), context_inst(), pick_dest(w),
				int'(next_rand() % 5));
			if (n % 4 == 3) write_reg(5'(next_rand()), next_rand());
		end
		repeat (2) @(posedge clock);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule
